// ==== sources.f ====
cpu_pkg.sv
pipe_regs.sv
fetch_unit.sv
reg_file.sv
decode_unit.sv
hazard_unit.sv
execute_unit.sv
mem_access.sv
cpu_top.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_cpu -f sources.f \
	-o tb_cpu_sim && ./obj_dir/tb_cpu_sim > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } || echo "simulation passed"

// ==== tb_cpu.sv ====
module tb_cpu import cpu_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int prog_len       = 32;
	localparam int timeout_cycles = prog_len * 10 + 50;

	logic    clk       = 1'b0;
	logic    arst_n    = 1'b0;
	word_t   inst_adr;
	word_t   inst_dat  = '0;
	wb_m2s_t wb_o;
	wb_s2m_t wb_i      = '0;
	retire_t retire;

	word_t   rom [256];
	word_t   mem [256];
	word_t   sh_mem [256];
	word_t   sh_regs [4];
	word_t   sh_pc;
	retire_t expected;
	integer  seed      = 32'h37c7;
	int      wait_left;
	logic    busy;
	logic    halt_seen = 1'b0;
	int      retired   = 0;
	int      cycles    = 0;

	cpu_top #(.reset_pc(16'h0000)) uut (
		.clk(clk), .arst_n(arst_n),
		.inst_adr(inst_adr), .inst_dat(inst_dat),
		.wb_o(wb_o), .wb_i(wb_i),
		.retire(retire)
	);

	always #2 clk = ~clk;

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input word_t expected_val, input word_t actual);
		if (actual !== expected_val) begin
			fail_now($sformatf("Error: %s expected %h actual %h", name, expected_val, actual));
		end
	endtask

	task automatic expect_idle(input string when);
		check($sformatf("%s retire.valid", when), '0, word_t'(retire.valid));
		check($sformatf("%s cyc", when), '0, word_t'(wb_o.cyc));
		check($sformatf("%s stb", when), '0, word_t'(wb_o.stb));
	endtask

	function automatic word_t sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	// data memory start contents, shared by the slave and the shadow copy
	function automatic word_t fill_word(input int i);
		return {i[7:0], ~i[7:0]};
	endfunction

	function automatic word_t rtype_word(input funct_t fn, input reg_idx_t rs,
		input reg_idx_t rt, input reg_idx_t rd);
		instr_u w;
		w.r.opcode = op_rtype;
		w.r.rs     = rs;
		w.r.rt     = rt;
		w.r.rd     = rd;
		w.r.funct  = fn;
		return word_t'(w);
	endfunction

	function automatic word_t itype_word(input opcode_t op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [7:0] imm);
		instr_u w;
		w.i.opcode = op;
		w.i.rs     = rs;
		w.i.rt     = rt;
		w.i.imm8   = imm;
		return word_t'(w);
	endfunction

	function automatic word_t jmp_word(input logic [11:0] target);
		instr_u w;
		w.j.opcode   = op_jmp;
		w.j.target12 = target;
		return word_t'(w);
	endfunction

	task automatic load_program();
		for (int i = 0; i < 256; i++) begin
			rom[i] = {op_nop, 4'h0, i[7:0]};
		end
		rom[0]  = itype_word(op_adi, 2'd0, 2'd1, 8'd5);
		rom[1]  = itype_word(op_adi, 2'd0, 2'd2, 8'hfd);
		// both sources written by the two instructions before
		rom[2]  = rtype_word(fn_add, 2'd1, 2'd2, 2'd3);
		rom[3]  = rtype_word(fn_sub, 2'd1, 2'd3, 2'd0);
		rom[4]  = rtype_word(fn_and, 2'd3, 2'd0, 2'd1);
		rom[5]  = rtype_word(fn_orr, 2'd1, 2'd0, 2'd2);
		rom[6]  = itype_word(op_lhi, 2'd0, 2'd3, 8'h12);
		rom[7]  = rtype_word(fn_orr, 2'd3, 2'd2, 2'd3);
		rom[8]  = itype_word(op_swd, 2'd0, 2'd3, 8'd16);
		rom[9]  = itype_word(op_lwd, 2'd0, 2'd1, 8'd16);
		rom[10] = rtype_word(fn_add, 2'd1, 2'd1, 2'd2);   // load-use
		rom[11] = itype_word(op_lwd, 2'd0, 2'd3, 8'd40);
		rom[12] = itype_word(op_swd, 2'd0, 2'd2, 8'd20);
		rom[13] = itype_word(op_beq, 2'd1, 2'd2, 8'd5);
		rom[14] = itype_word(op_bne, 2'd1, 2'd2, 8'd2);
		rom[15] = itype_word(op_adi, 2'd0, 2'd0, 8'd1);
		rom[16] = itype_word(op_adi, 2'd0, 2'd0, 8'd1);
		rom[17] = itype_word(op_adi, 2'd0, 2'd1, 8'hff);
		rom[18] = itype_word(op_adi, 2'd0, 2'd0, 8'hfc);
		// loop runs three times, storing r2 at 32, 31, 30
		rom[19] = itype_word(op_adi, 2'd2, 2'd2, 8'd1);
		rom[20] = itype_word(op_swd, 2'd1, 2'd2, 8'd30);
		rom[21] = itype_word(op_adi, 2'd1, 2'd1, 8'hff);
		rom[22] = itype_word(op_bne, 2'd1, 2'd0, 8'hfc);
		rom[23] = itype_word(op_lwd, 2'd1, 2'd3, 8'd32);
		rom[24] = jmp_word(12'd27);
		rom[25] = itype_word(op_adi, 2'd3, 2'd3, 8'd1);
		// wrong-path halt, must never take effect
		rom[26] = rtype_word(fn_hlt, 2'd0, 2'd0, 2'd0);
		rom[27] = rtype_word(fn_add, 2'd3, 2'd2, 2'd0);
		rom[28] = itype_word(op_beq, 2'd0, 2'd0, 8'd1);
		rom[29] = itype_word(op_lhi, 2'd0, 2'd0, 8'hff);
		rom[30] = nop_word;
		rom[31] = rtype_word(fn_hlt, 2'd0, 2'd0, 2'd0);
	endtask

	// ISA model, one architectural instruction per call
	function automatic retire_t ref_step();
		instr_u  iw;
		opcode_t op;
		retire_t res;
		word_t   ra;
		word_t   rb;
		word_t   ea;
		word_t   next_pc;
		iw      = rom[sh_pc[7:0]];
		op      = iw.r.opcode;
		ra      = sh_regs[iw.i.rs];
		rb      = sh_regs[iw.i.rt];
		ea      = ra + sext8(iw.i.imm8);
		next_pc = sh_pc + 16'd1;
		res       = '0;
		res.valid = 1'b1;
		res.pc    = sh_pc;
		res.dest  = (op == op_rtype) ? iw.r.rd : iw.i.rt;
		res.writes = (op inside {op_adi, op_lhi, op_lwd}) ||
			(op == op_rtype && iw.r.funct inside {fn_add, fn_sub, fn_and, fn_orr});
		case (op)
			op_rtype: begin
				res.halt = iw.r.funct == fn_hlt;
				case (iw.r.funct)
					fn_add:  res.value = ra + rb;
					fn_sub:  res.value = ra - rb;
					fn_and:  res.value = ra & rb;
					fn_orr:  res.value = ra | rb;
					default: res.value = '0;
				endcase
			end
			op_adi: res.value = ea;
			op_lhi: res.value = {iw.i.imm8, 8'h00};
			op_lwd: res.value = sh_mem[ea[7:0]];
			op_swd: sh_mem[ea[7:0]] = rb;
			op_beq: next_pc = (ra == rb) ? next_pc + sext8(iw.i.imm8) : next_pc;
			op_bne: next_pc = (ra != rb) ? next_pc + sext8(iw.i.imm8) : next_pc;
			op_jmp: next_pc = {sh_pc[15:12], iw.j.target12};
			default: res.value = '0;
		endcase
		if (res.writes) begin
			sh_regs[res.dest] = res.value;
		end
		sh_pc = next_pc;
		return res;
	endfunction

	// instruction ROM, read back within the same cycle
	initial begin
		load_program();
		forever begin
			@(posedge clk);
			#0.5;
			inst_dat = rom[inst_adr[7:0]];
		end
	end

	// Wishbone slave with 0 to 3 wait cycles per access
	initial begin
		busy      = 1'b0;
		wait_left = 0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
		end
		forever begin
			@(posedge clk);
			#0.5;
			wb_i.ack = 1'b0;
			if (wb_o.cyc && wb_o.stb) begin
				if (!busy) begin
					busy      = 1'b1;
					wait_left = $random(seed) & 3;
				end
				if (wait_left == 0) begin
					wb_i.ack   = 1'b1;
					wb_i.dat_r = mem[wb_o.adr[7:0]];
					if (wb_o.we) begin
						mem[wb_o.adr[7:0]] = wb_o.dat_w;
					end
					busy = 1'b0;
				end else begin
					wait_left--;
				end
			end
		end
	end

	// retire checker, compares each record with the ISA model in order
	initial begin
		sh_pc = 16'h0000;
		for (int i = 0; i < 4; i++) begin
			sh_regs[i] = '0;
		end
		for (int i = 0; i < 256; i++) begin
			sh_mem[i] = fill_word(i);
		end
		forever begin
			@(negedge clk);
			if (retire.valid) begin
				if (halt_seen) begin
					fail_now($sformatf("an instruction at pc %h retired after HLT", retire.pc));
				end
				expected = ref_step();
				check($sformatf("retire %0d pc", retired), expected.pc, retire.pc);
				check($sformatf("retire %0d writes", retired), word_t'(expected.writes),
					word_t'(retire.writes));
				check($sformatf("retire %0d halt", retired), word_t'(expected.halt),
					word_t'(retire.halt));
				if (expected.writes) begin
					check($sformatf("retire %0d dest", retired), word_t'(expected.dest),
						word_t'(retire.dest));
					check($sformatf("retire %0d value", retired), expected.value, retire.value);
				end
				retired++;
				if (expected.halt) begin
					halt_seen = 1'b1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > timeout_cycles) begin
			fail_now($sformatf("the core never halted within %0d cycles", timeout_cycles));
		end
	end

	initial begin
		@(posedge clk);
		@(negedge clk);
		expect_idle("in reset");
		@(posedge clk);
		#0.5;
		arst_n = 1'b1;
		@(negedge clk);
		expect_idle("first cycle after reset");
		wait (halt_seen);
		// nothing may retire once the core has halted
		repeat (20) @(posedge clk);
		for (int i = 0; i < 256; i++) begin
			check($sformatf("memory word %0d", i), sh_mem[i], mem[i]);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

// ==== cpu_top.sv ====
module cpu_top import cpu_pkg::*; #(
	parameter word_t reset_pc = 16'h0000
) (
	input  logic    clk,
	input  logic    arst_n,
	output word_t   inst_adr,
	input  word_t   inst_dat,
	output wb_m2s_t wb_o,
	input  wb_s2m_t wb_i,
	output retire_t retire
);
	if_id_t   fetched;
	if_id_t   if_id_q;
	id_ex_t   id_ex_d;
	id_ex_t   id_ex_q;
	ex_mem_t  ex_mem_d;
	ex_mem_t  ex_mem_q;
	mem_wb_t  mem_wb_d;
	mem_wb_t  mem_wb_q;
	logic     src_a_used;
	logic     src_b_used;
	reg_idx_t src_a;
	reg_idx_t src_b;
	logic     stall;
	logic     flush;
	logic     redirect;
	word_t    redirect_pc;
	logic     halt_req;
	logic     mem_wait;

	fetch_unit #(.reset_pc(reset_pc)) u_fetch (
		.clk(clk), .arst_n(arst_n),
		.hold(mem_wait), .stall(stall),
		.redirect(redirect), .redirect_pc(redirect_pc), .halt_req(halt_req),
		.inst_dat(inst_dat), .inst_adr(inst_adr),
		.fetched(fetched)
	);

	if_id_reg u_if_id (
		.clk(clk), .arst_n(arst_n),
		.hold(mem_wait), .stall(stall), .flush(flush),
		.d(fetched), .q(if_id_q)
	);

	decode_unit u_decode (
		.clk(clk), .arst_n(arst_n),
		.in(if_id_q), .wb(mem_wb_q), .out(id_ex_d),
		.src_a_used(src_a_used), .src_b_used(src_b_used),
		.src_a(src_a), .src_b(src_b)
	);

	hazard_unit u_hazard (
		.src_a_used(src_a_used), .src_b_used(src_b_used),
		.src_a(src_a), .src_b(src_b),
		.ex(id_ex_q), .mem(ex_mem_q),
		.redirect(redirect), .stall(stall), .flush(flush)
	);

	id_ex_reg u_id_ex (
		.clk(clk), .arst_n(arst_n),
		.hold(mem_wait), .bubble(stall || flush),
		.d(id_ex_d), .q(id_ex_q)
	);

	execute_unit u_execute (
		.in(id_ex_q), .out(ex_mem_d),
		.redirect(redirect), .redirect_pc(redirect_pc), .halt_req(halt_req)
	);

	ex_mem_reg u_ex_mem (
		.clk(clk), .arst_n(arst_n),
		.hold(mem_wait),
		.d(ex_mem_d), .q(ex_mem_q)
	);

	mem_access u_mem (
		.clk(clk), .arst_n(arst_n),
		.in(ex_mem_q), .wb_o(wb_o), .wb_i(wb_i),
		.mem_wait(mem_wait), .out(mem_wb_d)
	);

	mem_wb_reg u_mem_wb (
		.clk(clk), .arst_n(arst_n),
		.hold(mem_wait),
		.d(mem_wb_d), .q(mem_wb_q)
	);

	assign retire.valid  = mem_wb_q.valid;
	assign retire.pc     = mem_wb_q.pc;
	assign retire.writes = mem_wb_q.writes;
	assign retire.dest   = mem_wb_q.dest;
	assign retire.value  = mem_wb_q.value;
	assign retire.halt   = mem_wb_q.is_halt;

endmodule

// ==== mem_access.sv ====
module mem_access import cpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  ex_mem_t in,
	output wb_m2s_t wb_o,
	input  wb_s2m_t wb_i,
	output logic    mem_wait,
	output mem_wb_t out
);
	logic  mem_op;
	logic  req;
	logic  ack_q;
	word_t ack_pc;

	assign mem_op = in.valid && (in.is_load || in.is_store);

	// an entry already acked last cycle must not open a second bus cycle
	assign req = mem_op && !(ack_q && in.pc == ack_pc);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req && wb_i.ack;
		end
	end

	always_ff @(posedge clk) begin
		if (req && wb_i.ack) begin
			ack_pc <= in.pc;
		end
	end

	assign wb_o.cyc   = req;
	assign wb_o.stb   = req;
	assign wb_o.we    = in.is_store;
	assign wb_o.adr   = in.result;
	assign wb_o.dat_w = in.store_data;

	assign mem_wait = req && !wb_i.ack;

	assign out.valid   = in.valid;
	assign out.pc      = in.pc;
	assign out.value   = in.is_load ? wb_i.dat_r : in.result;
	assign out.writes  = in.writes;
	assign out.dest    = in.dest;
	assign out.is_halt = in.is_halt;

	// ex_mem moves on at the ack edge
	a_advance_on_ack: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_o.stb && wb_i.ack) |=> !in.valid || in.pc != $past(in.pc));

	// the frozen ex_mem entry keeps the request steady across wait states
	a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
		(wb_o.stb && !wb_i.ack) |=> wb_o.stb && $stable(wb_o.adr) && $stable(wb_o.we));

endmodule

// ==== execute_unit.sv ====
module execute_unit import cpu_pkg::*; (
	input  id_ex_t  in,
	output ex_mem_t out,
	output logic    redirect,
	output word_t   redirect_pc,
	output logic    halt_req
);
	opcode_t op;
	funct_t  fn;
	word_t   alu;
	word_t   br_target;
	word_t   jmp_target;
	logic    taken;

	assign op = opcode_t'(in.instr[15:12]);
	assign fn = funct_t'(in.instr[5:0]);

	always_comb begin
		case (op)
			op_rtype: begin
				case (fn)
					fn_add:  alu = in.a + in.b;
					fn_sub:  alu = in.a - in.b;
					fn_and:  alu = in.a & in.b;
					fn_orr:  alu = in.a | in.b;
					default: alu = '0;
				endcase
			end
			op_lhi: alu = in.imm;
			// also the word address of LWD/SWD
			op_adi, op_lwd, op_swd: alu = in.a + in.imm;
			default: alu = '0;
		endcase
	end

	// beq wants equal operands, bne wants them different
	assign taken      = in.is_branch && ((op == op_beq) == (in.a == in.b));
	assign br_target  = in.pc + 16'd1 + in.imm;
	assign jmp_target = {in.pc[15:12], in.imm[11:0]};

	assign redirect = in.valid && (taken || in.is_jump || in.is_halt);
	assign halt_req = in.valid && in.is_halt;

	always_comb begin
		if (in.is_halt) begin
			redirect_pc = in.pc;
		end else if (in.is_jump) begin
			redirect_pc = jmp_target;
		end else begin
			redirect_pc = br_target;
		end
	end

	assign out.valid      = in.valid;
	assign out.pc         = in.pc;
	assign out.result     = alu;
	assign out.store_data = in.b;
	assign out.writes     = in.writes;
	assign out.dest       = in.dest;
	assign out.is_load    = in.is_load;
	assign out.is_store   = in.is_store;
	assign out.is_halt    = in.is_halt;

endmodule

// ==== hazard_unit.sv ====
module hazard_unit import cpu_pkg::*; (
	input  logic     src_a_used,
	input  logic     src_b_used,
	input  reg_idx_t src_a,
	input  reg_idx_t src_b,
	input  id_ex_t   ex,
	input  ex_mem_t  mem,
	input  logic     redirect,
	output logic     stall,
	output logic     flush
);
	logic ex_wr;
	logic mem_wr;
	logic hit_a;
	logic hit_b;

	// producers still ahead of writeback
	assign ex_wr  = ex.valid && ex.writes;
	assign mem_wr = mem.valid && mem.writes;

	assign hit_a = src_a_used && ((ex_wr && ex.dest == src_a) || (mem_wr && mem.dest == src_a));
	assign hit_b = src_b_used && ((ex_wr && ex.dest == src_b) || (mem_wr && mem.dest == src_b));

	assign stall = hit_a || hit_b;
	assign flush = redirect;

endmodule

// ==== decode_unit.sv ====
module decode_unit import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  if_id_t   in,
	input  mem_wb_t  wb,
	output id_ex_t   out,
	output logic     src_a_used,
	output logic     src_b_used,
	output reg_idx_t src_a,
	output reg_idx_t src_b
);
	instr_u iw;
	word_t  rd_a;
	word_t  rd_b;
	logic   use_a;
	logic   use_b;

	assign iw    = in.instr;
	assign src_a = iw.i.rs;
	assign src_b = iw.i.rt;

	reg_file u_rf (
		.clk(clk), .arst_n(arst_n),
		.ra(src_a), .rb(src_b),
		.a(rd_a), .b(rd_b),
		.we(wb.valid && wb.writes),
		.wa(wb.dest),
		.wd(wb.value)
	);

	always_comb begin
		out       = '0;
		out.valid = in.valid;
		out.pc    = in.pc;
		out.instr = in.instr;
		out.a     = rd_a;
		out.b     = rd_b;
		out.imm   = {{8{iw.i.imm8[7]}}, iw.i.imm8};
		out.dest  = iw.i.rt;
		use_a     = 1'b0;
		use_b     = 1'b0;
		case (iw.r.opcode)
			op_rtype: begin
				out.is_halt = iw.r.funct == fn_hlt;
				if (iw.r.funct inside {fn_add, fn_sub, fn_and, fn_orr}) begin
					out.writes = 1'b1;
					out.dest   = iw.r.rd;
					use_a      = 1'b1;
					use_b      = 1'b1;
				end
			end
			op_adi: begin
				out.writes = 1'b1;
				use_a      = 1'b1;
			end
			op_lhi: begin
				out.writes = 1'b1;
				out.imm    = {iw.i.imm8, 8'h00};
			end
			op_lwd: begin
				out.writes  = 1'b1;
				out.is_load = 1'b1;
				use_a       = 1'b1;
			end
			op_swd: begin
				out.is_store = 1'b1;
				use_a        = 1'b1;
				use_b        = 1'b1;
			end
			op_bne, op_beq: begin
				out.is_branch = 1'b1;
				use_a         = 1'b1;
				use_b         = 1'b1;
			end
			op_jmp: begin
				out.is_jump = 1'b1;
				out.imm     = {4'h0, iw.j.target12};
			end
			default: begin
				out.writes = 1'b0;
			end
		endcase
	end

	// an empty slot must never trigger the interlock
	assign src_a_used = in.valid && use_a;
	assign src_b_used = in.valid && use_b;

endmodule

// ==== reg_file.sv ====
module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t ra,
	input  reg_idx_t rb,
	output word_t    a,
	output word_t    b,
	input  logic     we,
	input  reg_idx_t wa,
	input  word_t    wd
);
	word_t regs [4];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 4; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wa] <= wd;
		end
	end

	// write-through, decode sees the value being written back this cycle
	assign a = (we && wa == ra) ? wd : regs[ra];
	assign b = (we && wa == rb) ? wd : regs[rb];

endmodule

// ==== fetch_unit.sv ====
module fetch_unit import cpu_pkg::*; #(
	parameter word_t reset_pc = 16'h0000
) (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   hold,
	input  logic   stall,
	input  logic   redirect,
	input  word_t  redirect_pc,
	input  logic   halt_req,
	input  word_t  inst_dat,
	output word_t  inst_adr,
	output if_id_t fetched
);
	word_t pc;
	logic  halted;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc     <= reset_pc;
			halted <= 1'b0;
		end else if (!hold && !halted) begin
			// redirect from execute beats the interlock
			if (redirect) begin
				pc     <= redirect_pc;
				halted <= halt_req;
			end else if (!stall) begin
				pc <= pc + 16'd1;
			end
		end
	end

	assign inst_adr      = pc;
	assign fetched.valid = !halted;
	assign fetched.pc    = pc;
	assign fetched.instr = halted ? nop_word : inst_dat;

endmodule

// ==== pipe_regs.sv ====
module if_id_reg import cpu_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   hold,
	input  logic   stall,
	input  logic   flush,
	input  if_id_t d,
	output if_id_t q
);
	localparam if_id_t bubble_rec = '{valid: 1'b0, pc: '0, instr: nop_word};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= bubble_rec;
		end else if (!hold) begin
			if (flush) begin
				q <= bubble_rec;
			end else if (!stall) begin
				q <= d;
			end
		end
	end

endmodule

module id_ex_reg import cpu_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   hold,
	input  logic   bubble,
	input  id_ex_t d,
	output id_ex_t q
);
	localparam id_ex_t bubble_rec = '{instr: nop_word, default: '0};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= bubble_rec;
		end else if (!hold) begin
			q <= bubble ? bubble_rec : d;
		end
	end

endmodule

module ex_mem_reg import cpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    hold,
	input  ex_mem_t d,
	output ex_mem_t q
);
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

module mem_wb_reg import cpu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  logic    hold,
	input  mem_wb_t d,
	output mem_wb_t q
);
	// writeback must not repeat while memory waits, so hold means bubble here
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (hold) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

// ==== cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [1:0] reg_idx_t;

	typedef enum logic [3:0] {
		op_bne   = 4'd0,
		op_beq   = 4'd1,
		op_adi   = 4'd4,
		op_lhi   = 4'd6,
		op_lwd   = 4'd7,
		op_swd   = 4'd8,
		op_jmp   = 4'd9,
		op_nop   = 4'd14,
		op_rtype = 4'd15
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_hlt = 6'd29
	} funct_t;

	typedef struct packed {
		opcode_t  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		funct_t   funct;
	} r_view_t;

	typedef struct packed {
		opcode_t    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		logic [7:0] imm8;
	} i_view_t;

	typedef struct packed {
		opcode_t     opcode;
		logic [11:0] target12;
	} j_view_t;

	// one instruction word, three field layouts
	typedef union packed {
		r_view_t r;
		i_view_t i;
		j_view_t j;
	} instr_u;

	localparam word_t nop_word = {op_nop, 12'h000};

	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    instr;
		word_t    a;
		word_t    b;
		word_t    imm;
		logic     writes;
		reg_idx_t dest;
		logic     is_load;
		logic     is_store;
		logic     is_branch;
		logic     is_jump;
		logic     is_halt;
	} id_ex_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    result;
		word_t    store_data;
		logic     writes;
		reg_idx_t dest;
		logic     is_load;
		logic     is_store;
		logic     is_halt;
	} ex_mem_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		word_t    value;
		logic     writes;
		reg_idx_t dest;
		logic     is_halt;
	} mem_wb_t;

	typedef struct packed {
		logic     valid;
		word_t    pc;
		logic     writes;
		reg_idx_t dest;
		word_t    value;
		logic     halt;
	} retire_t;

	typedef struct packed {
		logic  cyc;
		logic  stb;
		logic  we;
		word_t adr;
		word_t dat_w;
	} wb_m2s_t;

	typedef struct packed {
		logic  ack;
		word_t dat_r;
	} wb_s2m_t;

endpackage
